// File: include/vdc_cfg.svh
// Build-time sizes for the display controller
// The video memory depth is fixed here and is not host selectable
// VDC_CHAR_W must stay equal to the video byte width in bitmap mode
`ifndef VDC_CFG_SVH
`define VDC_CFG_SVH

// Video memory address width, 14 bits gives 16K bytes
`define VDC_RAM_BITS 14

// Pixels per character cell, one video byte per cell
`define VDC_CHAR_W 8

`endif

// File: hdl/vdc_pkg.sv
// Shared types of the display controller
// Register numbers follow the 80-column controller map, unused numbers read FF
`include "vdc_cfg.svh"

package vdc_pkg;

	typedef enum logic [5:0] {
		R_HT   = 6'd0,  // Horizontal total minus 1
		R_HD   = 6'd1,  // Horizontal displayed
		R_HP   = 6'd2,  // Hsync position
		R_SW   = 6'd3,  // Vsync width [7:4], hsync width [3:0]
		R_VT   = 6'd4,  // Vertical total minus 1
		R_VD   = 6'd6,  // Vertical displayed
		R_VP   = 6'd7,  // Vsync position
		R_CTV  = 6'd9,  // Scanlines per row minus 1
		R_DSH  = 6'd12, // Display start high
		R_DSL  = 6'd13, // Display start low
		R_LPV  = 6'd16, // Light pen row
		R_LPH  = 6'd17, // Light pen column
		R_UAH  = 6'd18, // Update address high
		R_UAL  = 6'd19, // Update address low
		R_COL  = 6'd26, // Foreground [7:4], background [3:0]
		R_DATA = 6'd31  // Video memory data port
	} reg_idx_e;

	typedef enum logic [2:0] {
		UPD_NONE,
		UPD_SET_HI,
		UPD_SET_LO,
		UPD_WRITE,  // Store then increment
		UPD_READ    // Present then increment
	} upd_op_e;

	typedef struct packed {
		logic [7:0] ht;
		logic [7:0] hd;
		logic [7:0] hp;
		logic [3:0] hw;
		logic [7:0] vt;
		logic [7:0] vd;
		logic [7:0] vp;
		logic [3:0] vw;
		logic [4:0] ctv;
	} crtc_cfg_t;

	typedef struct packed {
		logic [`VDC_RAM_BITS-1:0] ds;
		logic [3:0]               fg;
		logic [3:0]               bg;
	} disp_cfg_t;

	typedef struct packed {
		logic [7:0] col;
		logic [7:0] row;
		logic [4:0] line;
		logic       char_start;  // First pixel of a cell
		logic       hdisp;
		logic       vdisp;
		logic       frame_start; // First pixel of a frame
	} beam_t;

	typedef struct packed {
		upd_op_e    op;
		logic [7:0] data;
	} upd_req_t;

	typedef struct packed {
		logic [`VDC_RAM_BITS-1:0] ua;
		logic [7:0]               rdata;
	} upd_rsp_t;

endpackage

// File: hdl/vdc_regs.sv
// Host register file with a single-cycle cs strobe and no wait states
// db_out is registered and holds its value until the next read
// Only the bitmap-mode subset of the register map is implemented
`timescale 1ns/100ps
`include "vdc_cfg.svh"

module vdc_regs (
	input  logic                clk,
	input  logic                reset,
	input  logic                cs,
	input  logic                we,
	input  logic                rs,
	input  logic [7:0]          db_in,
	input  logic                lp_n,
	input  vdc_pkg::beam_t      beam,
	input  vdc_pkg::upd_rsp_t   upd_rsp,
	output logic [7:0]          db_out,
	output vdc_pkg::crtc_cfg_t  crtc_cfg,
	output vdc_pkg::disp_cfg_t  disp_cfg,
	output vdc_pkg::upd_req_t   upd_req
);
	import vdc_pkg::*;

	logic [5:0]  regsel;   // Selected register, any 6-bit value
	logic [7:0]  lpv;      // Latched light pen row
	logic [7:0]  lph;      // Latched light pen column
	logic        lp_flag;
	logic        lp_q;     // Previous lp_n for edge detect
	logic        wr_stb;
	logic        rd_stb;
	logic [15:0] ua_pad;   // Upper unused bits read as 1
	logic [15:0] ds_pad;
	logic [7:0]  rd_byte;

	assign wr_stb = cs & we;
	assign rd_stb = cs & ~we;
	assign ua_pad = {{(16 - `VDC_RAM_BITS){1'b1}}, upd_rsp.ua};
	assign ds_pad = {{(16 - `VDC_RAM_BITS){1'b1}}, disp_cfg.ds};

	// Update port ops fire in the same cycle as the strobe
	always_comb begin
		upd_req.op   = UPD_NONE;
		upd_req.data = db_in;
		if (cs && rs) begin
			case (regsel)
				R_UAH:   if (we) upd_req.op = UPD_SET_HI;
				R_UAL:   if (we) upd_req.op = UPD_SET_LO;
				R_DATA:  upd_req.op = we ? UPD_WRITE : UPD_READ;
				default: upd_req.op = UPD_NONE;
			endcase
		end
	end

	// Read data mux
	always_comb begin
		if (!rs) begin
			rd_byte = {1'b1, lp_flag, ~beam.vdisp, 5'b00000}; // Ready, pen, vblank
		end else begin
			case (regsel)
				R_HT:    rd_byte = crtc_cfg.ht;
				R_HD:    rd_byte = crtc_cfg.hd;
				R_HP:    rd_byte = crtc_cfg.hp;
				R_SW:    rd_byte = {crtc_cfg.vw, crtc_cfg.hw};
				R_VT:    rd_byte = crtc_cfg.vt;
				R_VD:    rd_byte = crtc_cfg.vd;
				R_VP:    rd_byte = crtc_cfg.vp;
				R_CTV:   rd_byte = {3'b111, crtc_cfg.ctv};
				R_DSH:   rd_byte = ds_pad[15:8];
				R_DSL:   rd_byte = ds_pad[7:0];
				R_LPV:   rd_byte = lpv;
				R_LPH:   rd_byte = lph;
				R_UAH:   rd_byte = ua_pad[15:8];
				R_UAL:   rd_byte = ua_pad[7:0];
				R_COL:   rd_byte = {disp_cfg.fg, disp_cfg.bg};
				R_DATA:  rd_byte = upd_rsp.rdata; // Byte at ua before the increment
				default: rd_byte = 8'hff;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regsel   <= '0;
			crtc_cfg <= '0;
			disp_cfg <= '0;
			db_out   <= '0;
			lpv      <= '0;
			lph      <= '0;
			lp_flag  <= 1'b0;
			lp_q     <= 1'b1; // Idle level of the active-low pen input
		end else begin
			lp_q <= lp_n;

			if (wr_stb && !rs)
				regsel <= db_in[5:0];

			if (wr_stb && rs) begin
				case (regsel)
					R_HT:  crtc_cfg.ht <= db_in;
					R_HD:  crtc_cfg.hd <= db_in;
					R_HP:  crtc_cfg.hp <= db_in;
					R_SW: begin
						crtc_cfg.vw <= db_in[7:4];
						crtc_cfg.hw <= db_in[3:0];
					end
					R_VT:  crtc_cfg.vt  <= db_in;
					R_VD:  crtc_cfg.vd  <= db_in;
					R_VP:  crtc_cfg.vp  <= db_in;
					R_CTV: crtc_cfg.ctv <= db_in[4:0];
					R_DSH: disp_cfg.ds[`VDC_RAM_BITS-1:8] <= db_in[`VDC_RAM_BITS-9:0];
					R_DSL: disp_cfg.ds[7:0] <= db_in;
					R_COL: begin
						disp_cfg.fg <= db_in[7:4];
						disp_cfg.bg <= db_in[3:0];
					end
					default: ; // Read-only, update port or unused
				endcase
			end

			if (rd_stb)
				db_out <= rd_byte;

			// Reading either pen register rearms the latch
			if (rd_stb && rs && (regsel == R_LPV || regsel == R_LPH))
				lp_flag <= 1'b0;

			if (!lp_q && lp_n && !lp_flag) begin
				lpv     <= beam.row;
				lph     <= beam.col;
				lp_flag <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/vdc_timing.sv
// Raster timing, one pixel per clk
// Counters wrap at or beyond their totals, so shrinking a total mid-frame is safe
// Sync and blank are registered and lag the beam counters by one clk
`timescale 1ns/100ps
`include "vdc_cfg.svh"

module vdc_timing (
	input  logic               clk,
	input  logic               reset,
	input  vdc_pkg::crtc_cfg_t crtc_cfg,
	output vdc_pkg::beam_t     beam,
	output logic               hsync,
	output logic               vsync,
	output logic               hblank,
	output logic               vblank
);
	localparam int PIX_W = $clog2(`VDC_CHAR_W);

	logic [PIX_W-1:0] pix;     // Pixel within cell
	logic [7:0]       col;
	logic [7:0]       row;
	logic [4:0]       line;    // Scanline within row
	logic [3:0]       vs_cnt;  // Vsync scanlines left after this one
	logic             last_pix;
	logic             last_col;
	logic             last_line;
	logic             line_start;
	logic [8:0]       hs_end;  // One past last hsync column

	assign last_pix   = (pix == PIX_W'(`VDC_CHAR_W - 1));
	assign last_col   = (col >= crtc_cfg.ht);
	assign last_line  = (line >= crtc_cfg.ctv);
	assign line_start = (pix == '0) && (col == '0);
	assign hs_end     = {1'b0, crtc_cfg.hp} + {5'b00000, crtc_cfg.hw};

	// Beam counters
	always_ff @(posedge clk) begin
		if (reset) begin
			pix  <= '0;
			col  <= '0;
			line <= '0;
			row  <= '0;
		end else begin
			pix <= last_pix ? '0 : pix + 1'b1;
			if (last_pix) begin
				if (last_col) begin
					col <= '0;
					if (last_line) begin
						line <= '0;
						row  <= (row >= crtc_cfg.vt) ? '0 : row + 1'b1;
					end else begin
						line <= line + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Sync and blank
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync  <= 1'b0;
			vsync  <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			vs_cnt <= '0;
		end else begin
			hsync  <= ({1'b0, col} >= {1'b0, crtc_cfg.hp}) && ({1'b0, col} < hs_end);
			hblank <= (col >= crtc_cfg.hd);
			vblank <= (row >= crtc_cfg.vd);
			if (line_start) begin
				if (row == crtc_cfg.vp && line == '0 && crtc_cfg.vw != '0) begin
					vs_cnt <= crtc_cfg.vw - 1'b1; // First vsync scanline
					vsync  <= 1'b1;
				end else if (vs_cnt != '0) begin
					vs_cnt <= vs_cnt - 1'b1;
				end else begin
					vsync <= 1'b0;
				end
			end
		end
	end

	assign beam.col         = col;
	assign beam.row         = row;
	assign beam.line        = line;
	assign beam.char_start  = (pix == '0);
	assign beam.hdisp       = (col < crtc_cfg.hd);
	assign beam.vdisp       = (row < crtc_cfg.vd);
	assign beam.frame_start = line_start && (line == '0) && (row == '0);

endmodule

// File: hdl/vdc_fetch.sv
// Video memory with a host update port and a display fetch port
// Host reads are combinational from ua so the register block can latch them at once
// Display bytes are fetched one cell ahead of the pixel shifter
`timescale 1ns/100ps
`include "vdc_cfg.svh"

module vdc_fetch (
	input  logic               clk,
	input  logic               reset,
	input  vdc_pkg::disp_cfg_t disp_cfg,
	input  vdc_pkg::beam_t     beam,
	input  vdc_pkg::upd_req_t  upd_req,
	output vdc_pkg::upd_rsp_t  upd_rsp,
	output logic [7:0]         vbyte,
	output logic               vload
);
	import vdc_pkg::*;

	logic [7:0]               vram [2**`VDC_RAM_BITS];
	logic [`VDC_RAM_BITS-1:0] ua;        // Auto-incrementing update address
	logic [`VDC_RAM_BITS-1:0] daddr;     // Next display address
	logic [`VDC_RAM_BITS-1:0] faddr;     // Address fetched this cell
	logic                     fetch_vld; // vbyte holds a displayed cell
	logic                     disp_cell;

	assign disp_cell = beam.char_start & beam.hdisp & beam.vdisp;
	assign faddr     = beam.frame_start ? disp_cfg.ds : daddr; // Restart at ds each frame

	// Host port address
	always_ff @(posedge clk) begin
		if (reset) begin
			ua <= '0;
		end else begin
			case (upd_req.op)
				UPD_SET_HI: ua[`VDC_RAM_BITS-1:8] <= upd_req.data[`VDC_RAM_BITS-9:0];
				UPD_SET_LO: ua[7:0] <= upd_req.data;
				UPD_WRITE,
				UPD_READ:   ua <= ua + 1'b1;
				default:    ;
			endcase
		end
	end

	// Host write port
	always_ff @(posedge clk) begin
		if (upd_req.op == UPD_WRITE)
			vram[ua] <= upd_req.data;
	end

	// Display read port
	always_ff @(posedge clk) begin
		if (disp_cell)
			vbyte <= vram[faddr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			daddr     <= '0;
			fetch_vld <= 1'b0;
		end else begin
			if (beam.frame_start)
				daddr <= disp_cfg.ds;
			if (disp_cell)
				daddr <= faddr + 1'b1; // One byte per displayed cell
			if (beam.char_start)
				fetch_vld <= beam.hdisp & beam.vdisp;
		end
	end

	assign vload         = beam.char_start & fetch_vld;
	assign upd_rsp.ua    = ua;
	assign upd_rsp.rdata = vram[ua];

endmodule

// File: hdl/vdc_pixel.sv
// Bitmap pixel shifter, MSB first, one pixel per clk
// Output is black whenever the loaded cell was outside the display
`timescale 1ns/100ps
`include "vdc_cfg.svh"

module vdc_pixel (
	input  logic               clk,
	input  logic               reset,
	input  vdc_pkg::disp_cfg_t disp_cfg,
	input  vdc_pkg::beam_t     beam,
	input  logic [7:0]         vbyte,
	input  logic               vload,
	output logic [3:0]         rgbi
);
	logic [`VDC_CHAR_W-1:0] shifter;
	logic                   disp_en; // Display enable delayed to match the shifter

	always_ff @(posedge clk) begin
		if (vload)
			shifter <= vbyte;
		else
			shifter <= {shifter[`VDC_CHAR_W-2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (reset)
			disp_en <= 1'b0;
		else if (beam.char_start)
			disp_en <= vload; // Held for the whole cell
	end

	// Foreground for a one, background for a zero
	assign rgbi = !disp_en ? 4'h0 :
	              shifter[`VDC_CHAR_W-1] ? disp_cfg.fg : disp_cfg.bg;

endmodule

// File: hdl/vdc_top.sv
// Bitmap-only CRT controller, every clk is one pixel
// No bus wait states, the video memory never stalls the host
`timescale 1ns/100ps

module vdc_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       cs,
	input  logic       we,
	input  logic       rs,
	input  logic       lp_n,
	input  logic [7:0] db_in,
	output logic [7:0] db_out,
	output logic       hsync,
	output logic       vsync,
	output logic       hblank,
	output logic       vblank,
	output logic [3:0] rgbi
);
	import vdc_pkg::*;

	crtc_cfg_t  crtc_cfg;
	disp_cfg_t  disp_cfg;
	beam_t      beam;
	upd_req_t   upd_req;
	upd_rsp_t   upd_rsp;
	logic [7:0] vbyte;
	logic       vload;

	vdc_regs i_vdc_regs (
		.clk      (clk),
		.reset    (reset),
		.cs       (cs),
		.we       (we),
		.rs       (rs),
		.db_in    (db_in),
		.lp_n     (lp_n),
		.beam     (beam),
		.upd_rsp  (upd_rsp),
		.db_out   (db_out),
		.crtc_cfg (crtc_cfg),
		.disp_cfg (disp_cfg),
		.upd_req  (upd_req)
	);

	vdc_timing i_vdc_timing (
		.clk      (clk),
		.reset    (reset),
		.crtc_cfg (crtc_cfg),
		.beam     (beam),
		.hsync    (hsync),
		.vsync    (vsync),
		.hblank   (hblank),
		.vblank   (vblank)
	);

	vdc_fetch i_vdc_fetch (
		.clk      (clk),
		.reset    (reset),
		.disp_cfg (disp_cfg),
		.beam     (beam),
		.upd_req  (upd_req),
		.upd_rsp  (upd_rsp),
		.vbyte    (vbyte),
		.vload    (vload)
	);

	vdc_pixel i_vdc_pixel (
		.clk      (clk),
		.reset    (reset),
		.disp_cfg (disp_cfg),
		.beam     (beam),
		.vbyte    (vbyte),
		.vload    (vload),
		.rgbi     (rgbi)
	);

endmodule

// File: bench/vdc_sva.sv
// Bus and sync assertions, bound into every vdc_top instance
// fail_count is read by the testbench for its closing summary
`timescale 1ns/100ps

module vdc_sva (
	input logic       clk,
	input logic       reset,
	input logic       cs,
	input logic       we,
	input logic [7:0] db_out,
	input logic       hsync,
	input logic       vsync,
	input logic       hblank
);
	int fail_count;

	initial fail_count = 0;

	// Read data is registered, so it may only move one clk after a read strobe
	a_db_hold: assert property (@(posedge clk) disable iff (reset)
		$changed(db_out) |-> $past(cs && !we))
	else begin
		fail_count++;
		$error("db_out changed without a preceding read strobe");
	end

	a_sync_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !hsync && !vsync)
	else begin
		fail_count++;
		$error("sync output active while reset is held");
	end

	a_hsync_blank: assert property (@(posedge clk) disable iff (reset)
		hsync |-> hblank)
	else begin
		fail_count++;
		$error("hsync active outside horizontal blank");
	end

endmodule

bind vdc_top vdc_sva i_vdc_sva (
	.clk    (clk),
	.reset  (reset),
	.cs     (cs),
	.we     (we),
	.db_out (db_out),
	.hsync  (hsync),
	.vsync  (vsync),
	.hblank (hblank)
);

// File: bench/vdc_tb.sv
// Directed testbench for the bitmap CRT controller
// Inputs change 1 ns after the rising clk edge, raster outputs are sampled on the falling edge
// Video bytes come from a Galois LFSR with a fixed seed, one step per bit
`timescale 1ns/100ps
`include "vdc_cfg.svh"

module vdc_tb;
	import vdc_pkg::*;

	localparam int     CLK_PERIOD   = 8;
	localparam int     ADDR_HI_BITS = `VDC_RAM_BITS - 8; // Implemented bits of R12 and R18
	localparam int     FRAME_CLK    = 10 * `VDC_CHAR_W * 6 * 4; // ht=9, vt=5, ctv=3
	localparam int     TEST_FRAMES  = 8;    // Frames waited on in the timing tests
	localparam int     BUS_CLK      = 1500; // All bus accesses together
	localparam longint WATCHDOG_NS  = 2 * (TEST_FRAMES * FRAME_CLK + BUS_CLK) * CLK_PERIOD;
	localparam logic [3:0] FG = 4'ha;
	localparam logic [3:0] BG = 4'h5;

	logic       clk;
	logic       reset;
	logic       cs;
	logic       we;
	logic       rs;
	logic       lp_n;
	logic [7:0] db_in;
	logic [7:0] db_out;
	logic       hsync;
	logic       vsync;
	logic       hblank;
	logic       vblank;
	logic [3:0] rgbi;

	int          errors;
	longint      cycle;       // Rising edges since time 0
	logic [31:0] lfsr_state;
	logic [7:0]  vdata [32];  // Bytes last written to video memory

	vdc_top i_vdc_top (
		.clk    (clk),
		.reset  (reset),
		.cs     (cs),
		.we     (we),
		.rs     (rs),
		.lp_n   (lp_n),
		.db_in  (db_in),
		.db_out (db_out),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank),
		.rgbi   (rgbi)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [7:0] next_random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]}; // Output bit is the LSB
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return b;
	endfunction

	// Unimplemented upper bits of a register read back as 1
	function automatic logic [7:0] pad_high(input logic [7:0] value, input int width);
		logic [7:0] mask;
		mask = 8'hff << width;
		return value | mask;
	endfunction

	function automatic logic signal_level(input int sel);
		case (sel)
			0:       return hsync;
			1:       return vsync;
			2:       return hblank;
			default: return vblank;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
	                               input logic [31:0] actual);
		errors++;
		$display("[ERROR] %s expected %0h got %0h at %0t", name, expected, actual, $time);
	endtask

	task automatic bus_write(input logic sel, input logic [7:0] data);
		@(posedge clk);
		#1;
		cs    = 1'b1;
		we    = 1'b1;
		rs    = sel;
		db_in = data;
		@(posedge clk);
		#1;
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_read(input logic sel, output logic [7:0] data);
		@(posedge clk);
		#1;
		cs = 1'b1;
		we = 1'b0;
		rs = sel;
		@(posedge clk);
		#1;
		cs   = 1'b0;
		data = db_out; // Latched on the strobe edge
	endtask

	task automatic select_reg(input logic [5:0] idx);
		bus_write(1'b0, {2'b00, idx});
	endtask

	task automatic reg_write(input logic [5:0] idx, input logic [7:0] value);
		select_reg(idx);
		bus_write(1'b1, value);
	endtask

	task automatic reg_read(input logic [5:0] idx, output logic [7:0] value);
		select_reg(idx);
		bus_read(1'b1, value);
	endtask

	task automatic wait_for_level(input int sel, input logic level, output longint stamp);
		do begin
			@(negedge clk);
		end while (signal_level(sel) !== level);
		stamp = cycle;
	endtask

	// Period and high time of one full pulse, in clk
	task automatic measure_pulse(input int sel, output longint period, output longint high);
		longint t_rise;
		longint t_fall;
		longint t_next;
		wait_for_level(sel, 1'b0, t_fall);
		wait_for_level(sel, 1'b1, t_rise);
		wait_for_level(sel, 1'b0, t_fall);
		wait_for_level(sel, 1'b1, t_next);
		period = t_next - t_rise;
		high   = t_fall - t_rise;
	endtask

	task automatic check_reset_state();
		if (hsync !== 1'b0) report_mismatch("hsync", 0, hsync);
		if (vsync !== 1'b0) report_mismatch("vsync", 0, vsync);
		if (rgbi !== 4'h0) report_mismatch("rgbi", 0, rgbi);
		if (db_out !== 8'h00) report_mismatch("db_out", 0, db_out);
	endtask

	task automatic test_registers();
		logic [5:0] idx [13] = '{R_HT, R_HD, R_HP, R_SW, R_VT, 6'd5, R_VD, R_VP, 6'd8,
		                         R_CTV, R_DSH, R_DSL, R_COL};
		logic [7:0] val [13] = '{8'h13, 8'h05, 8'h0a, 8'h32, 8'h07, 8'h5e, 8'h06, 8'h04,
		                         8'h77, 8'h41, 8'h02, 8'h5a, 8'h9c};
		int         width [13] = '{8, 8, 8, 8, 8, 0, 8, 8, 0, 5, ADDR_HI_BITS, 8, 8};
		logic [7:0] got;
		for (int i = 0; i < 13; i++)
			reg_write(idx[i], val[i]); // hd below hp keeps hsync inside blank
		for (int i = 0; i < 13; i++) begin
			reg_read(idx[i], got);
			if (got !== pad_high(val[i], width[i]))
				report_mismatch($sformatf("R%0d", idx[i]), pad_high(val[i], width[i]), got);
		end
		reg_read(6'd40, got);
		if (got !== 8'hff) report_mismatch("R40", 8'hff, got);
	endtask

	task automatic test_update_port();
		logic [7:0] got;
		reg_write(R_UAH, 8'h01);
		reg_write(R_UAL, 8'h00);
		select_reg(R_DATA);
		for (int i = 0; i < 16; i++) begin
			vdata[i] = next_random_byte();
			bus_write(1'b1, vdata[i]);
		end
		reg_read(R_UAH, got);
		if (got !== pad_high(8'h01, ADDR_HI_BITS))
			report_mismatch("R18", pad_high(8'h01, ADDR_HI_BITS), got);
		reg_read(R_UAL, got);
		if (got !== 8'h10) report_mismatch("R19", 8'h10, got);
		reg_write(R_UAH, 8'h01);
		reg_write(R_UAL, 8'h00);
		select_reg(R_DATA);
		for (int i = 0; i < 16; i++) begin
			bus_read(1'b1, got);
			if (got !== vdata[i]) report_mismatch($sformatf("R31 byte %0d", i), vdata[i], got);
		end
	endtask

	task automatic test_sync_timing();
		int     ht;
		int     hd;
		int     hp;
		int     hw;
		int     vt;
		int     vd;
		int     vw;
		int     ctv;
		longint period;
		longint high;
		ht  = 9;
		hd  = 5;
		hp  = 6;
		hw  = 2;
		vt  = 5;
		vd  = 4;
		vw  = 2;
		ctv = 3;
		reg_write(R_HT, 8'(ht));
		reg_write(R_HP, 8'(hp)); // Before hd, so hp never drops below hd
		reg_write(R_HD, 8'(hd));
		reg_write(R_SW, {4'(vw), 4'(hw)});
		reg_write(R_VT, 8'(vt));
		reg_write(R_CTV, 8'(ctv));
		reg_write(R_VD, 8'(vd));
		reg_write(R_VP, 8'd4);
		measure_pulse(0, period, high);
		if (period != (ht + 1) * `VDC_CHAR_W)
			report_mismatch("hsync period", (ht + 1) * `VDC_CHAR_W, period);
		if (high != hw * `VDC_CHAR_W) report_mismatch("hsync high", hw * `VDC_CHAR_W, high);
		measure_pulse(1, period, high);
		if (period != (ht + 1) * `VDC_CHAR_W * (vt + 1) * (ctv + 1))
			report_mismatch("vsync period", (ht + 1) * `VDC_CHAR_W * (vt + 1) * (ctv + 1), period);
		if (high != vw * (ht + 1) * `VDC_CHAR_W)
			report_mismatch("vsync high", vw * (ht + 1) * `VDC_CHAR_W, high);
		measure_pulse(2, period, high);
		if (period - high != hd * `VDC_CHAR_W)
			report_mismatch("hblank low", hd * `VDC_CHAR_W, period - high);
		measure_pulse(3, period, high); // Displayed rows times full scanlines
		if (period - high != vd * (ctv + 1) * (ht + 1) * `VDC_CHAR_W)
			report_mismatch("vblank low", vd * (ctv + 1) * (ht + 1) * `VDC_CHAR_W, period - high);
	endtask

	task automatic test_pixels();
		int     ones;
		int     fg_count;
		longint stamp;
		reg_write(R_HD, 8'd4);
		reg_write(R_VD, 8'd2);
		reg_write(R_CTV, 8'd3);
		reg_write(R_DSH, 8'h02); // ds = 0x0200
		reg_write(R_DSL, 8'h00);
		reg_write(R_COL, {FG, BG});
		reg_write(R_UAH, 8'h02);
		reg_write(R_UAL, 8'h00);
		select_reg(R_DATA);
		ones = 0;
		for (int i = 0; i < 32; i++) begin // 4 cells x 2 rows x 4 scanlines
			vdata[i] = next_random_byte();
			ones += $countones(vdata[i]);
			bus_write(1'b1, vdata[i]);
		end
		wait_for_level(1, 1'b0, stamp);
		wait_for_level(1, 1'b1, stamp); // Frame boundary, display rows follow
		fg_count = 0;
		do begin
			@(negedge clk);
			if (rgbi === FG) fg_count++;
		end while (vsync !== 1'b0);
		do begin
			@(negedge clk);
			if (rgbi === FG) fg_count++;
		end while (vsync !== 1'b1);
		if (fg_count != ones) report_mismatch("rgbi fg pixel count", ones, fg_count);
	endtask

	task automatic test_status_pen();
		logic [7:0] status;
		logic [7:0] pen;
		longint     stamp;
		wait_for_level(3, 1'b1, stamp); // Inside vertical blank
		bus_read(1'b0, status);
		if (status !== 8'ha0) report_mismatch("status", 8'ha0, status);
		@(posedge clk);
		#1;
		lp_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		lp_n = 1'b1; // Rising edge latches the beam
		repeat (2) @(posedge clk);
		bus_read(1'b0, status);
		if ((status & 8'hc0) !== 8'hc0) report_mismatch("status[7:6]", 8'hc0, status & 8'hc0);
		reg_read(R_LPV, pen);
		if (pen > 8'd5) begin
			errors++;
			$display("[ERROR] R16 expected at most 5 got %0h", pen);
		end
		reg_read(R_LPH, pen);
		if (pen > 8'd9) begin
			errors++;
			$display("[ERROR] R17 expected at most 9 got %0h", pen);
		end
		bus_read(1'b0, status);
		if (status[6] !== 1'b0) report_mismatch("status[6]", 0, status[6]);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		cs         = 1'b0;
		we         = 1'b0;
		rs         = 1'b0;
		lp_n       = 1'b1; // Pen input idles high
		db_in      = 8'h00;
		errors     = 0;
		cycle      = 0;
		lfsr_state = 32'h3272;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check_reset_state();
		test_registers();
		test_update_port();
		test_sync_timing();
		test_pixels();
		test_status_pen();
		$display("Check errors: %0d, assertion failures: %0d", errors,
		         i_vdc_top.i_vdc_sva.fail_count);
		if (errors == 0 && i_vdc_top.i_vdc_sva.fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: vdc_top.f
+incdir+include
hdl/vdc_pkg.sv
hdl/vdc_regs.sv
hdl/vdc_timing.sv
hdl/vdc_fetch.sv
hdl/vdc_pixel.sv
hdl/vdc_top.sv
bench/vdc_sva.sv
bench/vdc_tb.sv

// File: Bender.yml
package:
  name: vdc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vdc_pkg.sv
      - hdl/vdc_regs.sv
      - hdl/vdc_timing.sv
      - hdl/vdc_fetch.sv
      - hdl/vdc_pixel.sv
      - hdl/vdc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/vdc_sva.sv
      - bench/vdc_tb.sv
